// File: Bender.yml
package:
  name: rv_core

sources:
  - src/rv_isa_pkg.sv
  - src/rv_core_pkg.sv
  - src/rv_regfile.sv
  - src/rv_decode.sv
  - src/rv_execute.sv
  - src/rv_core_top.sv
  - target: simulation
    files:
      - sim/rv_core_props.sv
      - sim/rv_core_tb.sv

// File: sim/rv_core_props.sv
module rv_core_props #(
  parameter int XLEN = 32
) (
  input logic            clk,
  input logic            rst,
  input logic            in_ready_i,
  input logic            dec_valid_i,
  input logic            retire_valid_i,
  input logic            retire_ready_i,
  input logic [XLEN-1:0] retire_pc_i,
  input logic [XLEN-1:0] retire_data_i,
  input logic [XLEN-1:0] retire_target_i
);

  int fail_count = 0;

  // both stages come out of reset empty and ready to accept
  reset_clears: assert property (@(posedge clk)
    rst |=> !retire_valid_i && !dec_valid_i && in_ready_i)
    else begin
      $error("pipeline state not clear after reset");
      fail_count++;
    end

  retire_holds: assert property (@(posedge clk) disable iff (rst)
    retire_valid_i && !retire_ready_i |=>
      retire_valid_i && $stable(retire_data_i) && $stable(retire_pc_i)
      && $stable(retire_target_i))
    else begin
      $error("stalled retire output changed before the handshake");
      fail_count++;
    end

  // full pipe with a stalled retire must refuse new work
  issue_blocked: assert property (@(posedge clk) disable iff (rst)
    retire_valid_i && !retire_ready_i && dec_valid_i |-> !in_ready_i)
    else begin
      $error("issue port ready while decode and retire are both full and stalled");
      fail_count++;
    end

endmodule

// File: sim/rv_core_tb.sv
module rv_core_tb;

  localparam int XLEN = 32;

  typedef struct packed {
    logic [31:0] inst;
    logic [31:0] pc;
    logic [3:0]  rd;
    logic        wen;
    logic [31:0] data;
    logic        taken;
    logic [31:0] target;
    logic        illegal;
  } row_t;

  logic            clk;
  logic            rst;
  logic            in_valid_i;
  logic [31:0]     in_inst_i;
  logic [XLEN-1:0] in_pc_i;
  logic            in_ready_o;
  logic            retire_valid_o;
  logic            retire_ready_i;
  logic [XLEN-1:0] retire_pc_o;
  logic [3:0]      retire_rd_o;
  logic            retire_wen_o;
  logic [XLEN-1:0] retire_data_o;
  logic            retire_taken_o;
  logic [XLEN-1:0] retire_target_o;
  logic            retire_illegal_o;

  row_t   rows[$];
  int     retired = 0;
  int     cycles = 0;
  int     errors = 0;
  int     assert_fails;
  int     limit;
  integer seed = 32'h8654_cf0b;

  rv_core_top #(.XLEN(XLEN)) rv_core_top_inst (
    .clk(clk), .rst(rst),
    .in_valid_i(in_valid_i), .in_inst_i(in_inst_i), .in_pc_i(in_pc_i),
    .in_ready_o(in_ready_o),
    .retire_valid_o(retire_valid_o), .retire_ready_i(retire_ready_i),
    .retire_pc_o(retire_pc_o), .retire_rd_o(retire_rd_o), .retire_wen_o(retire_wen_o),
    .retire_data_o(retire_data_o), .retire_taken_o(retire_taken_o),
    .retire_target_o(retire_target_o), .retire_illegal_o(retire_illegal_o)
  );

  bind rv_core_top rv_core_props #(.XLEN(XLEN)) rv_core_props_inst (
    .clk, .rst,
    .in_ready_i(in_ready_o), .dec_valid_i(d_valid),
    .retire_valid_i(retire_valid_o), .retire_ready_i(retire_ready_i),
    .retire_pc_i(retire_pc_o), .retire_data_i(retire_data_o),
    .retire_target_i(retire_target_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycles++;

  // retire stalls about one cycle in four
  always @(negedge clk) retire_ready_i = ($random(seed) & 3) != 0;

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // pc follows the row position, the core never redirects
  function automatic void add_row(input logic [31:0] inst, input logic [3:0] rd, input bit wen,
                                  input logic [31:0] data, input bit taken,
                                  input logic [31:0] target, input bit illegal);
    row_t r;
    r.inst    = inst;
    r.pc      = 32'h0000_0100 + 32'(4 * rows.size());
    r.rd      = rd;
    r.wen     = wen;
    r.data    = data;
    r.taken   = taken;
    r.target  = target;
    r.illegal = illegal;
    rows.push_back(r);
  endfunction

  task automatic load_table();
    add_row(32'h00500093, 4'd1,  1, 32'h0000_0005, 0, 32'h0, 0);  // addi x1, x0, 5
    add_row(32'hFFD00113, 4'd2,  1, 32'hFFFF_FFFD, 0, 32'h0, 0);  // addi x2, x0, -3
    add_row(32'h123451B7, 4'd3,  1, 32'h1234_5000, 0, 32'h0, 0);  // lui x3, 0x12345
    add_row(32'h00001217, 4'd4,  1, 32'h0000_110C, 0, 32'h0, 0);  // auipc x4, 1
    add_row(32'hFFF12293, 4'd5,  1, 32'h0000_0001, 0, 32'h0, 0);  // slti x5, x2, -1
    add_row(32'h00409313, 4'd6,  1, 32'h0000_0050, 0, 32'h0, 0);  // slli x6, x1, 4
    add_row(32'h01C15393, 4'd7,  1, 32'h0000_000F, 0, 32'h0, 0);  // srli x7, x2, 28
    add_row(32'h40115413, 4'd8,  1, 32'hFFFF_FFFE, 0, 32'h0, 0);  // srai x8, x2, 1
    // dependent chain through the bypass
    add_row(32'h003084B3, 4'd9,  1, 32'h1234_5005, 0, 32'h0, 0);  // add x9, x1, x3
    add_row(32'h40148533, 4'd10, 1, 32'h1234_5000, 0, 32'h0, 0);  // sub x10, x9, x1
    add_row(32'h009545B3, 4'd11, 1, 32'h0000_0005, 0, 32'h0, 0);  // xor x11, x10, x9
    add_row(32'h0020B633, 4'd12, 1, 32'h0000_0001, 0, 32'h0, 0);  // sltu x12, x1, x2
    add_row(32'h40C456B3, 4'd13, 1, 32'hFFFF_FFFF, 0, 32'h0, 0);  // sra x13, x8, x12
    add_row(32'h00D68733, 4'd14, 1, 32'hFFFF_FFFE, 0, 32'h0, 0);  // add x14, x13, x13
    // branches, pc 0x138 onwards
    add_row(32'h00B08863, 4'd0,  0, 32'h0, 1, 32'h0000_0148, 0);  // beq x1, x11, +16
    add_row(32'h00B09863, 4'd0,  0, 32'h0, 0, 32'h0000_014C, 0);  // bne x1, x11, +16
    add_row(32'hFE114CE3, 4'd0,  0, 32'h0, 1, 32'h0000_0138, 0);  // blt x2, x1, -8
    add_row(32'hFE115CE3, 4'd0,  0, 32'h0, 0, 32'h0000_013C, 0);  // bge x2, x1, -8
    add_row(32'h00116863, 4'd0,  0, 32'h0, 0, 32'h0000_0158, 0);  // bltu x2, x1, +16
    add_row(32'h00117863, 4'd0,  0, 32'h0, 1, 32'h0000_015C, 0);  // bgeu x2, x1, +16
    add_row(32'h002087B3, 4'd15, 1, 32'h0000_0002, 0, 32'h0, 0);  // add x15, x1, x2
    add_row(32'h00B4E1B3, 4'd3,  1, 32'h1234_5005, 0, 32'h0, 0);  // or x3, x9, x11
    // jumps, link is pc + 4
    add_row(32'h020000EF, 4'd1,  1, 32'h0000_015C, 1, 32'h0000_0178, 0);  // jal x1, +32
    add_row(32'hFF1FF06F, 4'd0,  1, 32'h0000_0160, 1, 32'h0000_014C, 0);  // jal x0, -16
    add_row(32'h003082E7, 4'd5,  1, 32'h0000_0164, 1, 32'h0000_015E, 0);  // jalr x5, x1, 3
    add_row(32'hFFC28067, 4'd0,  1, 32'h0000_0168, 1, 32'h0000_0160, 0);  // jalr x0, x5, -4
    add_row(32'h00506333, 4'd6,  1, 32'h0000_0164, 0, 32'h0, 0);  // or x6, x0, x5
    add_row(32'h0000A383, 4'd0,  0, 32'h0, 0, 32'h0, 1);  // lw, not supported
    add_row(32'h00038433, 4'd8,  1, 32'h0000_000F, 0, 32'h0, 0);  // add x8, x7, x0
    add_row(32'h00112023, 4'd0,  0, 32'h0, 0, 32'h0, 1);  // sw, not supported
    add_row(32'hFFA58513, 4'd10, 1, 32'hFFFF_FFFF, 0, 32'h0, 0);  // addi x10, x11, -6
  endtask

  task automatic compare_retire(input row_t exp);
    check_value("retire_pc_o", retire_pc_o, exp.pc);
    check_value("retire_wen_o", retire_wen_o, exp.wen);
    check_value("retire_taken_o", retire_taken_o, exp.taken);
    check_value("retire_illegal_o", retire_illegal_o, exp.illegal);
    if (exp.wen) begin  // rd and data only carry meaning when written
      check_value("retire_rd_o", retire_rd_o, exp.rd);
      check_value("retire_data_o", retire_data_o, exp.data);
    end
    // target is defined for jumps and branches
    if (exp.taken || (!exp.wen && !exp.illegal)) begin
      check_value("retire_target_o", retire_target_o, exp.target);
    end
  endtask

  task automatic issue_all();
    for (int i = 0; i < rows.size(); i++) begin
      in_valid_i = 1'b1;
      in_inst_i  = rows[i].inst;
      in_pc_i    = rows[i].pc;
      @(posedge clk);
      while (!in_ready_o) begin
        @(posedge clk);
      end
      @(negedge clk);
    end
    in_valid_i = 1'b0;
  endtask

  // pre-edge values, the flops only move in the nba region
  always @(posedge clk) begin
    if (!rst && retire_valid_o && retire_ready_i) begin
      if (retired >= rows.size()) begin
        $display("error at %0t: retire handshake with no instruction left to retire", $time);
        errors++;
      end else begin
        compare_retire(rows[retired]);
      end
      retired++;
    end
  end

  initial begin
    rst            = 1'b1;
    in_valid_i     = 1'b0;
    in_inst_i      = '0;
    in_pc_i        = '0;
    retire_ready_i = 1'b0;
    load_table();
    limit = 20 * rows.size() + 50;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    fork
      issue_all();
    join_none
    while (retired < rows.size() && cycles < limit) begin
      @(negedge clk);
    end
    if (retired < rows.size()) begin
      $display("timeout: %0d of %0d instructions retired within %0d cycles",
               retired, rows.size(), limit);
      errors++;
    end else begin
      repeat (10) @(negedge clk);  // a repeated retire would show up here
      check_value("retire_valid_o", retire_valid_o, 1'b0);
      check_value("in_ready_o", in_ready_o, 1'b1);
    end
    assert_fails = rv_core_top_inst.rv_core_props_inst.fail_count;
    $display("summary: %0d check errors, %0d assertion failures, %0d retired",
             errors, assert_fails, retired);
    if (errors == 0 && assert_fails == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: src/rv_core_pkg.sv
package rv_core_pkg;

  // RV32E has 16 registers
  localparam int REG_IDX_W = 4;

  // encoded as {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } rv_alu_op_e;

endpackage

// File: src/rv_core_top.sv
module rv_core_top #(
  parameter int XLEN = 32
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              in_valid_i,
  input  rv_isa_pkg::rv_inst_u              in_inst_i,
  input  logic [XLEN-1:0]                   in_pc_i,
  output logic                              in_ready_o,
  output logic                              retire_valid_o,
  input  logic                              retire_ready_i,
  output logic [XLEN-1:0]                   retire_pc_o,
  output logic [rv_core_pkg::REG_IDX_W-1:0] retire_rd_o,
  output logic                              retire_wen_o,
  output logic [XLEN-1:0]                   retire_data_o,
  output logic                              retire_taken_o,
  output logic [XLEN-1:0]                   retire_target_o,
  output logic                              retire_illegal_o
);
  import rv_core_pkg::*;

  logic                 d_valid;
  rv_alu_op_e           d_alu_op;
  logic [XLEN-1:0]      d_op1;
  logic [XLEN-1:0]      d_op2;
  logic [REG_IDX_W-1:0] d_rd;
  logic                 d_wen;
  logic                 d_is_branch;
  logic [2:0]           d_funct3;
  logic                 d_is_jump;
  logic [XLEN-1:0]      d_target_base;
  logic [XLEN-1:0]      d_imm;
  logic [XLEN-1:0]      d_pc;
  logic                 d_illegal;
  logic                 x_ready;

  logic                 fwd_valid;
  logic [REG_IDX_W-1:0] fwd_rd;
  logic [XLEN-1:0]      fwd_data;

  logic [REG_IDX_W-1:0] rs1;
  logic [REG_IDX_W-1:0] rs2;
  logic [XLEN-1:0]      rdata1;
  logic [XLEN-1:0]      rdata2;

  wire rf_we = retire_valid_o & retire_ready_i & retire_wen_o;  // write on retire handshake

  rv_decode #(.XLEN(XLEN)) rv_decode_inst (
    .clk, .rst,
    .in_valid_i, .in_inst_i, .in_pc_i, .in_ready_o,
    .rs1_o(rs1), .rs2_o(rs2), .rdata1_i(rdata1), .rdata2_i(rdata2),
    .fwd_valid_i(fwd_valid), .fwd_rd_i(fwd_rd), .fwd_data_i(fwd_data),
    .x_ready_i(x_ready),
    .valid_o(d_valid), .alu_op_o(d_alu_op), .op1_o(d_op1), .op2_o(d_op2),
    .rd_o(d_rd), .wen_o(d_wen), .branch_o(d_is_branch), .funct3_o(d_funct3),
    .jump_o(d_is_jump), .base_o(d_target_base), .imm_o(d_imm), .pc_o(d_pc),
    .illegal_o(d_illegal)
  );

  rv_execute #(.XLEN(XLEN)) rv_execute_inst (
    .clk, .rst,
    .valid_i(d_valid), .alu_op_i(d_alu_op), .op1_i(d_op1), .op2_i(d_op2),
    .rd_i(d_rd), .wen_i(d_wen), .branch_i(d_is_branch), .funct3_i(d_funct3),
    .jump_i(d_is_jump), .base_i(d_target_base), .imm_i(d_imm), .pc_i(d_pc),
    .illegal_i(d_illegal), .x_ready_o(x_ready),
    .fwd_valid_o(fwd_valid), .fwd_rd_o(fwd_rd), .fwd_data_o(fwd_data),
    .retire_valid_o, .retire_ready_i, .retire_pc_o, .retire_rd_o, .retire_wen_o,
    .retire_data_o, .retire_taken_o, .retire_target_o, .retire_illegal_o
  );

  rv_regfile #(.XLEN(XLEN)) rv_regfile_inst (
    .clk, .rst,
    .raddr1_i(rs1), .raddr2_i(rs2),
    .rdata1_o(rdata1), .rdata2_o(rdata2),
    .we_i(rf_we), .waddr_i(retire_rd_o), .wdata_i(retire_data_o)
  );

endmodule

// File: src/rv_decode.sv
module rv_decode #(
  parameter int XLEN = 32
) (
  input  logic                              clk,
  input  logic                              rst,
  // issue side
  input  logic                              in_valid_i,
  input  rv_isa_pkg::rv_inst_u              in_inst_i,
  input  logic [XLEN-1:0]                   in_pc_i,
  output logic                              in_ready_o,
  // register file read
  output logic [rv_core_pkg::REG_IDX_W-1:0] rs1_o,
  output logic [rv_core_pkg::REG_IDX_W-1:0] rs2_o,
  input  logic [XLEN-1:0]                   rdata1_i,
  input  logic [XLEN-1:0]                   rdata2_i,
  // bypass from the retire register
  input  logic                              fwd_valid_i,
  input  logic [rv_core_pkg::REG_IDX_W-1:0] fwd_rd_i,
  input  logic [XLEN-1:0]                   fwd_data_i,
  // to execute
  input  logic                              x_ready_i,
  output logic                              valid_o,
  output rv_core_pkg::rv_alu_op_e           alu_op_o,
  output logic [XLEN-1:0]                   op1_o,
  output logic [XLEN-1:0]                   op2_o,
  output logic [rv_core_pkg::REG_IDX_W-1:0] rd_o,
  output logic                              wen_o,
  output logic                              branch_o,
  output logic [2:0]                        funct3_o,
  output logic                              jump_o,
  output logic [XLEN-1:0]                   base_o,
  output logic [XLEN-1:0]                   imm_o,
  output logic [XLEN-1:0]                   pc_o,
  output logic                              illegal_o
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  logic                 valid_q;
  rv_inst_u             inst_q;
  logic [XLEN-1:0]      pc_q;

  logic [REG_IDX_W-1:0] rs1_idx;
  logic [REG_IDX_W-1:0] rs2_idx;
  logic [XLEN-1:0]      rs1_val;
  logic [XLEN-1:0]      rs2_val;

  logic [XLEN-1:0]      imm_i;
  logic [XLEN-1:0]      imm_b;
  logic [XLEN-1:0]      imm_u;
  logic [XLEN-1:0]      imm_j;
  logic [2:0]           f3;
  logic                 alt_ok;

  // accept when empty or when the held instruction leaves this cycle
  assign in_ready_o = !valid_q || x_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      inst_q <= in_inst_i;
      pc_q   <= in_pc_i;
    end
  end

  // RV32E only sees the low four index bits
  assign rs1_idx = inst_q.r.rs1[REG_IDX_W-1:0];
  assign rs2_idx = inst_q.r.rs2[REG_IDX_W-1:0];
  assign rs1_o   = rs1_idx;
  assign rs2_o   = rs2_idx;

  assign rs1_val = (fwd_valid_i && fwd_rd_i == rs1_idx && rs1_idx != '0) ? fwd_data_i : rdata1_i;
  assign rs2_val = (fwd_valid_i && fwd_rd_i == rs2_idx && rs2_idx != '0) ? fwd_data_i : rdata2_i;

  assign imm_i = XLEN'($signed(inst_q.i.imm12));
  assign imm_b = XLEN'($signed({inst_q.r.funct7[6], inst_q.r.rd[0], inst_q.r.funct7[5:0],
                                inst_q.r.rd[4:1], 1'b0}));
  assign imm_u = XLEN'($signed({inst_q.u.imm20, 12'b0}));
  assign imm_j = XLEN'($signed({inst_q.u.imm20[19], inst_q.u.imm20[7:0], inst_q.u.imm20[8],
                                inst_q.u.imm20[18:9], 1'b0}));

  assign f3     = inst_q.r.funct3;
  assign alt_ok = (f3 == F3_ADD_SUB) || (f3 == F3_SR);  // only these have a funct7 variant

  assign valid_o  = valid_q;
  assign rd_o     = inst_q.r.rd[REG_IDX_W-1:0];
  assign funct3_o = f3;
  assign pc_o     = pc_q;

  always_comb begin
    alu_op_o  = ALU_ADD;
    op1_o     = '0;
    op2_o     = '0;
    wen_o     = 1'b0;
    branch_o  = 1'b0;
    jump_o    = 1'b0;
    base_o    = pc_q;
    imm_o     = XLEN'(4);  // fall-through pc as target by default
    illegal_o = 1'b0;
    case (inst_q.r.opcode)
      OPC_LUI: begin
        op2_o = imm_u;
        wen_o = 1'b1;
      end
      OPC_AUIPC: begin
        op1_o = pc_q;
        op2_o = imm_u;
        wen_o = 1'b1;
      end
      OPC_JAL: begin
        op1_o  = pc_q;
        op2_o  = XLEN'(4);  // link value
        wen_o  = 1'b1;
        jump_o = 1'b1;
        imm_o  = imm_j;
      end
      OPC_JALR: begin
        op1_o  = pc_q;
        op2_o  = XLEN'(4);
        wen_o  = 1'b1;
        jump_o = 1'b1;
        base_o = rs1_val;
        imm_o  = imm_i;
      end
      OPC_OP_IMM: begin
        alu_op_o = rv_alu_op_e'({(f3 == F3_SR) & inst_q.r.funct7[5], f3});  // srai
        op1_o    = rs1_val;
        op2_o    = imm_i;
        wen_o    = 1'b1;
      end
      OPC_OP: begin
        alu_op_o = rv_alu_op_e'({alt_ok & inst_q.r.funct7[5], f3});
        op1_o    = rs1_val;
        op2_o    = rs2_val;
        wen_o    = 1'b1;
      end
      OPC_BRANCH: begin
        op1_o    = rs1_val;
        op2_o    = rs2_val;
        branch_o = 1'b1;
        imm_o    = imm_b;
      end
      default: begin
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

// File: src/rv_execute.sv
module rv_execute #(
  parameter int XLEN = 32
) (
  input  logic                              clk,
  input  logic                              rst,
  // from decode
  input  logic                              valid_i,
  input  rv_core_pkg::rv_alu_op_e           alu_op_i,
  input  logic [XLEN-1:0]                   op1_i,
  input  logic [XLEN-1:0]                   op2_i,
  input  logic [rv_core_pkg::REG_IDX_W-1:0] rd_i,
  input  logic                              wen_i,
  input  logic                              branch_i,
  input  logic [2:0]                        funct3_i,
  input  logic                              jump_i,
  input  logic [XLEN-1:0]                   base_i,
  input  logic [XLEN-1:0]                   imm_i,
  input  logic [XLEN-1:0]                   pc_i,
  input  logic                              illegal_i,
  output logic                              x_ready_o,
  // bypass to decode
  output logic                              fwd_valid_o,
  output logic [rv_core_pkg::REG_IDX_W-1:0] fwd_rd_o,
  output logic [XLEN-1:0]                   fwd_data_o,
  // retire port
  output logic                              retire_valid_o,
  input  logic                              retire_ready_i,
  output logic [XLEN-1:0]                   retire_pc_o,
  output logic [rv_core_pkg::REG_IDX_W-1:0] retire_rd_o,
  output logic                              retire_wen_o,
  output logic [XLEN-1:0]                   retire_data_o,
  output logic                              retire_taken_o,
  output logic [XLEN-1:0]                   retire_target_o,
  output logic                              retire_illegal_o
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  localparam int SHAMT_W = $clog2(XLEN);

  logic [SHAMT_W-1:0] shamt;
  logic [XLEN-1:0]    alu_res;
  logic [XLEN-1:0]    sum;
  logic [XLEN-1:0]    target;
  logic               cond;
  logic               taken;

  assign shamt = op2_i[SHAMT_W-1:0];

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  alu_res = op1_i + op2_i;
      ALU_SUB:  alu_res = op1_i - op2_i;
      ALU_SLL:  alu_res = op1_i << shamt;
      ALU_SLT:  alu_res = XLEN'($signed(op1_i) < $signed(op2_i));
      ALU_SLTU: alu_res = XLEN'(op1_i < op2_i);
      ALU_XOR:  alu_res = op1_i ^ op2_i;
      ALU_SRL:  alu_res = op1_i >> shamt;
      ALU_SRA:  alu_res = XLEN'($signed(op1_i) >>> shamt);
      ALU_OR:   alu_res = op1_i | op2_i;
      ALU_AND:  alu_res = op1_i & op2_i;
      default:  alu_res = '0;
    endcase
  end

  always_comb begin
    case (funct3_i)
      F3_BEQ:  cond = (op1_i == op2_i);
      F3_BNE:  cond = (op1_i != op2_i);
      F3_BLT:  cond = ($signed(op1_i) < $signed(op2_i));
      F3_BGE:  cond = ($signed(op1_i) >= $signed(op2_i));
      F3_BLTU: cond = (op1_i < op2_i);
      F3_BGEU: cond = (op1_i >= op2_i);
      default: cond = 1'b0;
    endcase
  end

  assign taken  = jump_i || (branch_i && cond);
  assign sum    = base_i + imm_i;
  assign target = {sum[XLEN-1:1], sum[0] & ~jump_i};  // jalr clears bit 0

  // retire register drains on the handshake or sits empty
  assign x_ready_o = !retire_valid_o || retire_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid_o <= 1'b0;
    end else if (x_ready_o) begin
      retire_valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && x_ready_o) begin
      retire_pc_o      <= pc_i;
      retire_rd_o      <= rd_i;
      retire_wen_o     <= wen_i & ~branch_i & ~illegal_i;
      retire_data_o    <= alu_res;
      retire_taken_o   <= taken;
      retire_target_o  <= target;
      retire_illegal_o <= illegal_i;
    end
  end

  assign fwd_valid_o = retire_valid_o && retire_wen_o;
  assign fwd_rd_o    = retire_rd_o;
  assign fwd_data_o  = retire_data_o;

endmodule

// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

  // major opcodes handled by the core, everything else is illegal
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } rv_opcode_e;

  // funct3 values where funct7[5] selects the alternate op
  localparam logic [2:0] F3_ADD_SUB = 3'b000;  // add / sub
  localparam logic [2:0] F3_SR      = 3'b101;  // srl / sra

  // branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // register-register layout, also the source of the B immediate bits
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    rv_opcode_e opcode;
  } rv_r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    rv_opcode_e  opcode;
  } rv_i_fmt_t;

  // upper layout, J immediate is scrambled inside imm20
  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    rv_opcode_e  opcode;
  } rv_u_fmt_t;

  typedef union packed {
    rv_r_fmt_t r;
    rv_i_fmt_t i;
    rv_u_fmt_t u;
  } rv_inst_u;

endpackage

// File: src/rv_regfile.sv
module rv_regfile #(
  parameter int XLEN = 32
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [rv_core_pkg::REG_IDX_W-1:0] raddr1_i,
  input  logic [rv_core_pkg::REG_IDX_W-1:0] raddr2_i,
  output logic [XLEN-1:0]                  rdata1_o,
  output logic [XLEN-1:0]                  rdata2_o,
  input  logic                             we_i,
  input  logic [rv_core_pkg::REG_IDX_W-1:0] waddr_i,
  input  logic [XLEN-1:0]                  wdata_i
);
  import rv_core_pkg::*;

  localparam int NREGS = 2 ** REG_IDX_W;

  logic [XLEN-1:0] regs [1:NREGS-1];  // no storage behind x0

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 1; k < NREGS; k++) begin
        regs[k] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // asynchronous reads, x0 reads as zero
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// File: vlog.f
src/rv_isa_pkg.sv
src/rv_core_pkg.sv
src/rv_regfile.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_core_top.sv
sim/rv_core_props.sv
sim/rv_core_tb.sv
